/* arcade_settings.svh */
`ifndef ARCADE_SETTINGS_SVH
`define ARCADE_SETTINGS_SVH

// host keyboard scan codes
`define KEY_UP      8'h75
`define KEY_DOWN    8'h72
`define KEY_LEFT    8'h6B
`define KEY_RIGHT   8'h74
`define KEY_COIN    8'h76 // esc
`define KEY_START1  8'h05 // f1
`define KEY_START2  8'h06 // f2
`define KEY_FIRE    8'h29 // space
`define KEY_BOMB    8'h11 // alt

`define RESET_HOLD  16 // core reset length in clk_sys cycles

`define SL_LEVEL_25 6'd47 // odd-line pixel levels
`define SL_LEVEL_50 6'd31
`define SL_LEVEL_75 6'd15

`endif

/* arcade_pkg.sv */
`default_nettype none

package arcade_pkg;

	typedef logic [7:0] scan_code_t;

	// joystick word: 0 right, 1 left, 2 down, 3 up, 4 fire, 5 bomb
	typedef logic [7:0] joy_t;

	typedef logic [7:0] pcm_t; // unsigned sample

	typedef logic [5:0] color_t;

	typedef logic [1:0] cfg_addr_t;

	typedef enum logic [1:0] {
		sl_off = 2'd0,
		sl_25  = 2'd1,
		sl_50  = 2'd2,
		sl_75  = 2'd3
	} scanline_t;

	typedef enum logic {
		rs_idle = 1'b0,
		rs_hold = 1'b1
	} reset_state_t;

endpackage

`default_nettype wire

/* key_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "arcade_settings.svh"

module key_decoder (
	input  wire                     clk_sys,
	input  wire                     rst,
	input  wire                     key_strobe,
	input  wire arcade_pkg::scan_code_t key_code,
	input  wire                     key_pressed,
	output logic                    kb_up,
	output logic                    kb_down,
	output logic                    kb_left,
	output logic                    kb_right,
	output logic                    kb_fire,
	output logic                    kb_bomb,
	output logic                    kb_coin,
	output logic                    kb_start1,
	output logic                    kb_start2
);

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			kb_up     <= 1'b0;
			kb_down   <= 1'b0;
			kb_left   <= 1'b0;
			kb_right  <= 1'b0;
			kb_fire   <= 1'b0;
			kb_bomb   <= 1'b0;
			kb_coin   <= 1'b0;
			kb_start1 <= 1'b0;
			kb_start2 <= 1'b0;
		end else if (key_strobe) begin
			// held until the host reports the release
			case (key_code)
				`KEY_UP:     kb_up     <= key_pressed;
				`KEY_DOWN:   kb_down   <= key_pressed;
				`KEY_LEFT:   kb_left   <= key_pressed;
				`KEY_RIGHT:  kb_right  <= key_pressed;
				`KEY_FIRE:   kb_fire   <= key_pressed;
				`KEY_BOMB:   kb_bomb   <= key_pressed;
				`KEY_COIN:   kb_coin   <= key_pressed;
				`KEY_START1: kb_start1 <= key_pressed;
				`KEY_START2: kb_start2 <= key_pressed;
				default: ; // unmapped key
			endcase
		end
	end

endmodule

`default_nettype wire

/* control_mapper.sv */
`timescale 1ns/1ps
`default_nettype none

module control_mapper (
	input  wire                 clk_sys,
	input  wire                 rst,
	input  wire                 rotate,
	input  wire                 kb_up,
	input  wire                 kb_down,
	input  wire                 kb_left,
	input  wire                 kb_right,
	input  wire                 kb_fire,
	input  wire                 kb_bomb,
	input  wire                 kb_coin,
	input  wire                 kb_start1,
	input  wire                 kb_start2,
	input  wire arcade_pkg::joy_t joy0,
	input  wire arcade_pkg::joy_t joy1,
	output logic                ctrl_up,
	output logic                ctrl_down,
	output logic                ctrl_left,
	output logic                ctrl_right,
	output logic                ctrl_fire,
	output logic                ctrl_bomb,
	output logic                ctrl_coin,
	output logic                ctrl_start1,
	output logic                ctrl_start2
);

	logic in_up;
	logic in_down;
	logic in_left;
	logic in_right;

	// all three sources merged before rotation
	assign in_right = kb_right | joy0[0] | joy1[0];
	assign in_left  = kb_left  | joy0[1] | joy1[1];
	assign in_down  = kb_down  | joy0[2] | joy1[2];
	assign in_up    = kb_up    | joy0[3] | joy1[3];

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			ctrl_up     <= 1'b0;
			ctrl_down   <= 1'b0;
			ctrl_left   <= 1'b0;
			ctrl_right  <= 1'b0;
			ctrl_fire   <= 1'b0;
			ctrl_bomb   <= 1'b0;
			ctrl_coin   <= 1'b0;
			ctrl_start1 <= 1'b0;
			ctrl_start2 <= 1'b0;
		end else begin
			ctrl_up     <= rotate ? in_up    : in_right; // low means rotated cabinet
			ctrl_down   <= rotate ? in_down  : in_left;
			ctrl_left   <= rotate ? in_left  : in_up;
			ctrl_right  <= rotate ? in_right : in_down;
			ctrl_fire   <= kb_fire | joy0[4] | joy1[4];
			ctrl_bomb   <= kb_bomb | joy0[5] | joy1[5];
			ctrl_coin   <= kb_coin;
			ctrl_start1 <= kb_start1;
			ctrl_start2 <= kb_start2;
		end
	end

endmodule

`default_nettype wire

/* core_config.sv */
`timescale 1ns/1ps
`default_nettype none

`include "arcade_settings.svh"

module core_config (
	input  wire                      clk_sys,
	input  wire                      rst,
	input  wire                      cfg_wr,
	input  wire arcade_pkg::cfg_addr_t cfg_addr,
	input  wire [7:0]                cfg_data,
	input  wire                      reset_button,
	output logic                     rotate,
	output arcade_pkg::scanline_t    scanlines,
	output logic                     core_rst
);

	localparam int CNT_W = $clog2(`RESET_HOLD + 1);

	arcade_pkg::reset_state_t state;
	logic [CNT_W-1:0]         hold_cnt;
	logic                     reset_wr;

	assign reset_wr = cfg_wr && (cfg_addr == 2'd2);

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			rotate    <= 1'b0;
			scanlines <= arcade_pkg::sl_off;
		end else if (cfg_wr) begin
			case (cfg_addr)
				2'd0: rotate <= cfg_data[0];
				2'd1: scanlines <= arcade_pkg::scanline_t'(cfg_data[1:0]);
				default: ; // 2 handled by the reset fsm, 3 unused
			endcase
		end
	end

	// stretch a reset write to RESET_HOLD cycles
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			state    <= arcade_pkg::rs_idle;
			hold_cnt <= '0;
		end else if (reset_wr) begin
			state    <= arcade_pkg::rs_hold; // also restarts a running hold
			hold_cnt <= '0;
		end else if (state == arcade_pkg::rs_hold) begin
			if (hold_cnt == CNT_W'(`RESET_HOLD - 1))
				state <= arcade_pkg::rs_idle;
			hold_cnt <= hold_cnt + 1'b1;
		end
	end

	assign core_rst = rst | reset_button | (state == arcade_pkg::rs_hold);

endmodule

`default_nettype wire

/* audio_dac.sv */
`timescale 1ns/1ps
`default_nettype none

module audio_dac (
	input  wire                 clk_sys,
	input  wire                 rst,
	input  wire arcade_pkg::pcm_t core_audio,
	output logic                audio_out
);

	logic [8:0] acc; // bit 8 holds the last carry
	logic [8:0] acc_next;

	// first-order modulator, carry density equals sample / 256
	assign acc_next = {1'b0, acc[7:0]} + {1'b0, core_audio};

	always_ff @(posedge clk_sys) begin
		if (rst)
			acc <= '0;
		else
			acc <= acc_next;
	end

	assign audio_out = acc[8];

endmodule

`default_nettype wire

/* video_scanline.sv */
`timescale 1ns/1ps
`default_nettype none

`include "arcade_settings.svh"

module video_scanline (
	input  wire                       clk_sys,
	input  wire                       rst,
	input  wire arcade_pkg::scanline_t scanlines,
	input  wire                       core_video,
	input  wire                       core_hs,
	input  wire                       core_vs,
	output arcade_pkg::color_t        vga_r,
	output arcade_pkg::color_t        vga_g,
	output arcade_pkg::color_t        vga_b,
	output logic                      vga_hs,
	output logic                      vga_vs
);

	logic               odd_line;
	logic               hs_fall;
	logic               vs_fall;
	arcade_pkg::color_t on_level;

	// vga syncs are the previous core sync levels
	assign hs_fall = vga_hs & ~core_hs;
	assign vs_fall = vga_vs & ~core_vs;

	always_comb begin
		on_level = 6'd63;
		if (odd_line) begin
			case (scanlines)
				arcade_pkg::sl_25: on_level = `SL_LEVEL_25;
				arcade_pkg::sl_50: on_level = `SL_LEVEL_50;
				arcade_pkg::sl_75: on_level = `SL_LEVEL_75;
				default:           on_level = 6'd63;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			odd_line <= 1'b0;
			vga_hs   <= 1'b1; // idle high
			vga_vs   <= 1'b1;
			vga_r    <= '0;
			vga_g    <= '0;
			vga_b    <= '0;
		end else begin
			if (vs_fall)
				odd_line <= 1'b0; // frame starts on an even line
			else if (hs_fall)
				odd_line <= ~odd_line;
			vga_hs <= core_hs;
			vga_vs <= core_vs;
			vga_r  <= core_video ? on_level : 6'd0;
			vga_g  <= core_video ? on_level : 6'd0;
			vga_b  <= core_video ? on_level : 6'd0;
		end
	end

endmodule

`default_nettype wire

/* arcade_frontend.sv */
`timescale 1ns/1ps
`default_nettype none

module arcade_frontend (
	input  wire                        clk_sys,
	input  wire                        rst,
	input  wire                        key_strobe,
	input  wire arcade_pkg::scan_code_t key_code,
	input  wire                        key_pressed,
	input  wire arcade_pkg::joy_t      joy0,
	input  wire arcade_pkg::joy_t      joy1,
	input  wire                        cfg_wr,
	input  wire arcade_pkg::cfg_addr_t cfg_addr,
	input  wire [7:0]                  cfg_data,
	input  wire                        reset_button,
	input  wire                        core_video,
	input  wire                        core_hs,
	input  wire                        core_vs,
	input  wire arcade_pkg::pcm_t      core_audio,
	output logic                       ctrl_up,
	output logic                       ctrl_down,
	output logic                       ctrl_left,
	output logic                       ctrl_right,
	output logic                       ctrl_fire,
	output logic                       ctrl_bomb,
	output logic                       ctrl_coin,
	output logic                       ctrl_start1,
	output logic                       ctrl_start2,
	output logic                       core_rst,
	output logic                       audio_out,
	output arcade_pkg::color_t         vga_r,
	output arcade_pkg::color_t         vga_g,
	output arcade_pkg::color_t         vga_b,
	output logic                       vga_hs,
	output logic                       vga_vs
);

	logic                  kb_up;
	logic                  kb_down;
	logic                  kb_left;
	logic                  kb_right;
	logic                  kb_fire;
	logic                  kb_bomb;
	logic                  kb_coin;
	logic                  kb_start1;
	logic                  kb_start2;
	logic                  rotate;
	arcade_pkg::scanline_t scanlines;

	key_decoder i_key_decoder (
		.clk_sys    (clk_sys),
		.rst        (rst),
		.key_strobe (key_strobe),
		.key_code   (key_code),
		.key_pressed(key_pressed),
		.kb_up      (kb_up),
		.kb_down    (kb_down),
		.kb_left    (kb_left),
		.kb_right   (kb_right),
		.kb_fire    (kb_fire),
		.kb_bomb    (kb_bomb),
		.kb_coin    (kb_coin),
		.kb_start1  (kb_start1),
		.kb_start2  (kb_start2)
	);

	control_mapper i_control_mapper (
		.clk_sys    (clk_sys),
		.rst        (rst),
		.rotate     (rotate),
		.kb_up      (kb_up),
		.kb_down    (kb_down),
		.kb_left    (kb_left),
		.kb_right   (kb_right),
		.kb_fire    (kb_fire),
		.kb_bomb    (kb_bomb),
		.kb_coin    (kb_coin),
		.kb_start1  (kb_start1),
		.kb_start2  (kb_start2),
		.joy0       (joy0),
		.joy1       (joy1),
		.ctrl_up    (ctrl_up),
		.ctrl_down  (ctrl_down),
		.ctrl_left  (ctrl_left),
		.ctrl_right (ctrl_right),
		.ctrl_fire  (ctrl_fire),
		.ctrl_bomb  (ctrl_bomb),
		.ctrl_coin  (ctrl_coin),
		.ctrl_start1(ctrl_start1),
		.ctrl_start2(ctrl_start2)
	);

	core_config i_core_config (
		.clk_sys     (clk_sys),
		.rst         (rst),
		.cfg_wr      (cfg_wr),
		.cfg_addr    (cfg_addr),
		.cfg_data    (cfg_data),
		.reset_button(reset_button),
		.rotate      (rotate),
		.scanlines   (scanlines),
		.core_rst    (core_rst)
	);

	audio_dac i_audio_dac (
		.clk_sys   (clk_sys),
		.rst       (rst),
		.core_audio(core_audio),
		.audio_out (audio_out)
	);

	video_scanline i_video_scanline (
		.clk_sys   (clk_sys),
		.rst       (rst),
		.scanlines (scanlines),
		.core_video(core_video),
		.core_hs   (core_hs),
		.core_vs   (core_vs),
		.vga_r     (vga_r),
		.vga_g     (vga_g),
		.vga_b     (vga_b),
		.vga_hs    (vga_hs),
		.vga_vs    (vga_vs)
	);

endmodule

`default_nettype wire

/* arcade_frontend_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

`include "arcade_settings.svh"

module arcade_frontend_asserts (
	input wire                         clk_sys,
	input wire                         rst,
	input wire                         key_strobe,
	input wire arcade_pkg::scan_code_t key_code,
	input wire                         key_pressed,
	input wire arcade_pkg::joy_t       joy0,
	input wire arcade_pkg::joy_t       joy1,
	input wire                         cfg_wr,
	input wire arcade_pkg::cfg_addr_t  cfg_addr,
	input wire [7:0]                   cfg_data,
	input wire                         reset_button,
	input wire                         core_video,
	input wire                         core_hs,
	input wire                         core_vs,
	input wire [8:0]                   kb, // start2..fire, right, left, down, up
	input wire [8:0]                   ctrl,
	input wire                         rotate,
	input wire arcade_pkg::scanline_t  scanlines,
	input wire                         core_rst,
	input wire                         audio_out,
	input wire arcade_pkg::color_t     vga_r,
	input wire arcade_pkg::color_t     vga_g,
	input wire arcade_pkg::color_t     vga_b,
	input wire                         vga_hs,
	input wire                         vga_vs
);

	int unsigned               fail_count = 0;
	logic [`RESET_HOLD-1:0]    wr_hist;
	logic                      line_odd;
	logic                      hs_q;
	logic                      vs_q;
	logic [8:0]                kb_exp;
	logic [3:0]                dir_in; // joystick order: up, down, left, right
	logic [8:0]                ctrl_exp;
	arcade_pkg::color_t        pix_exp;

	function automatic logic [3:0] key_index(input arcade_pkg::scan_code_t code);
		case (code)
			`KEY_UP:     return 4'd0;
			`KEY_DOWN:   return 4'd1;
			`KEY_LEFT:   return 4'd2;
			`KEY_RIGHT:  return 4'd3;
			`KEY_FIRE:   return 4'd4;
			`KEY_BOMB:   return 4'd5;
			`KEY_COIN:   return 4'd6;
			`KEY_START1: return 4'd7;
			`KEY_START2: return 4'd8;
			default:     return 4'd9; // not a cabinet key
		endcase
	endfunction

	always_comb begin
		kb_exp = kb;
		if (key_strobe && key_index(key_code) != 4'd9)
			kb_exp[key_index(key_code)] = key_pressed;
	end

	assign dir_in = {kb[0] | joy0[3] | joy1[3], kb[1] | joy0[2] | joy1[2],
		kb[2] | joy0[1] | joy1[1], kb[3] | joy0[0] | joy1[0]};

	// rotated: up from right, down from left, left from up, right from down
	assign ctrl_exp[3:0] = rotate ? {dir_in[0], dir_in[1], dir_in[2], dir_in[3]}
		: {dir_in[2], dir_in[3], dir_in[1], dir_in[0]};
	assign ctrl_exp[8:4] = {kb[8], kb[7], kb[6], kb[5] | joy0[5] | joy1[5],
		kb[4] | joy0[4] | joy1[4]};

	always_comb begin
		if (!core_video)
			pix_exp = 6'd0;
		else if (!line_odd || scanlines == arcade_pkg::sl_off)
			pix_exp = 6'd63;
		else if (scanlines == arcade_pkg::sl_25)
			pix_exp = `SL_LEVEL_25;
		else if (scanlines == arcade_pkg::sl_50)
			pix_exp = `SL_LEVEL_50;
		else
			pix_exp = `SL_LEVEL_75;
	end

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			wr_hist  <= '0;
			line_odd <= 1'b0;
			hs_q     <= 1'b1;
			vs_q     <= 1'b1;
		end else begin
			wr_hist <= {wr_hist[`RESET_HOLD-2:0], cfg_wr && cfg_addr == 2'd2};
			hs_q    <= core_hs;
			vs_q    <= core_vs;
			if (vs_q && !core_vs)
				line_odd <= 1'b0;
			else if (hs_q && !core_hs)
				line_odd <= !line_odd;
		end
	end

	key_levels: assert property (@(posedge clk_sys) disable iff (rst)
		!rst |=> kb == $past(kb_exp))
		else begin
			fail_count++;
			$error("key decoder level does not follow the last key event");
		end

	ctrl_levels: assert property (@(posedge clk_sys) disable iff (rst)
		!rst |=> ctrl == $past(ctrl_exp))
		else begin
			fail_count++;
			$error("cabinet controls do not match merged and rotated inputs");
		end

	cfg_rotate: assert property (@(posedge clk_sys) disable iff (rst)
		!rst |=> rotate == $past((cfg_wr && cfg_addr == 2'd0) ? cfg_data[0] : rotate))
		else begin
			fail_count++;
			$error("rotate register does not follow its writes");
		end

	cfg_scanlines: assert property (@(posedge clk_sys) disable iff (rst)
		!rst |=> 2'(scanlines)
			== $past((cfg_wr && cfg_addr == 2'd1) ? cfg_data[1:0] : 2'(scanlines)))
		else begin
			fail_count++;
			$error("scanline register does not follow its writes");
		end

	core_reset: assert property (@(posedge clk_sys)
		core_rst == (rst || reset_button || (|wr_hist)))
		else begin
			fail_count++;
			$error("core reset length or source wrong");
		end

	video_out: assert property (@(posedge clk_sys) disable iff (rst)
		!rst |=> vga_r == $past(pix_exp) && vga_g == $past(pix_exp)
			&& vga_b == $past(pix_exp) && vga_hs == $past(core_hs)
			&& vga_vs == $past(core_vs))
		else begin
			fail_count++;
			$error("video level or sync alignment wrong");
		end

	reset_values: assert property (@(posedge clk_sys)
		rst |=> ctrl == '0 && !audio_out && vga_r == '0 && vga_g == '0
			&& vga_b == '0 && vga_hs && vga_vs)
		else begin
			fail_count++;
			$error("outputs not at their reset values");
		end

endmodule

bind arcade_frontend arcade_frontend_asserts i_asserts (
	.*,
	.kb({kb_start2, kb_start1, kb_coin, kb_bomb, kb_fire,
		kb_right, kb_left, kb_down, kb_up}),
	.ctrl({ctrl_start2, ctrl_start1, ctrl_coin, ctrl_bomb, ctrl_fire,
		ctrl_right, ctrl_left, ctrl_down, ctrl_up})
);

`default_nettype wire

/* tb_arcade_frontend.sv */
`timescale 1ns/1ps
`default_nettype none

`include "arcade_settings.svh"

module tb_arcade_frontend;

	logic                   clk_sys = 1'b0;
	logic                   rst;
	logic                   key_strobe;
	arcade_pkg::scan_code_t key_code;
	logic                   key_pressed;
	arcade_pkg::joy_t       joy0;
	arcade_pkg::joy_t       joy1;
	logic                   cfg_wr;
	arcade_pkg::cfg_addr_t  cfg_addr;
	logic [7:0]             cfg_data;
	logic                   reset_button;
	logic                   core_video;
	logic                   core_hs;
	logic                   core_vs;
	arcade_pkg::pcm_t       core_audio;
	logic                   ctrl_up;
	logic                   ctrl_down;
	logic                   ctrl_left;
	logic                   ctrl_right;
	logic                   ctrl_fire;
	logic                   ctrl_bomb;
	logic                   ctrl_coin;
	logic                   ctrl_start1;
	logic                   ctrl_start2;
	logic                   core_rst;
	logic                   audio_out;
	arcade_pkg::color_t     vga_r;
	arcade_pkg::color_t     vga_g;
	arcade_pkg::color_t     vga_b;
	logic                   vga_hs;
	logic                   vga_vs;

	int                     seed = 32'ha9bd_acda;
	int                     cycle_count = 0;
	logic [31:0]            rnd;
	arcade_pkg::scan_code_t key_list [9] = '{`KEY_UP, `KEY_DOWN, `KEY_LEFT, `KEY_RIGHT,
		`KEY_COIN, `KEY_START1, `KEY_START2, `KEY_FIRE, `KEY_BOMB};

	arcade_frontend i_dut (.*);

	always #50 clk_sys = ~clk_sys;

	task automatic stop_run(input string why);
		$display("Simulation failed");
		$fatal(1, "%s", why);
	endtask

	task automatic check_value(input string name, input int expected, input int actual);
		if (actual != expected) begin
			$display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
			stop_run("value mismatch");
		end
	endtask

	function automatic bit is_mapped(input arcade_pkg::scan_code_t code);
		foreach (key_list[i])
			if (key_list[i] == code)
				return 1'b1;
		return 1'b0;
	endfunction

	task automatic send_key(input arcade_pkg::scan_code_t code, input logic down);
		key_strobe  <= 1'b1;
		key_code    <= code;
		key_pressed <= down;
		@(posedge clk_sys);
		key_strobe <= 1'b0;
		repeat (3) @(posedge clk_sys); // decoder plus mapper latency
	endtask

	task automatic write_cfg(input arcade_pkg::cfg_addr_t addr, input logic [7:0] data);
		cfg_wr   <= 1'b1;
		cfg_addr <= addr;
		cfg_data <= data;
		@(posedge clk_sys);
		cfg_wr <= 1'b0;
		@(posedge clk_sys);
	endtask

	task automatic run_line(input int pixels);
		core_hs <= 1'b0;
		@(posedge clk_sys);
		core_hs <= 1'b1;
		repeat (pixels) begin
			rnd = $random(seed);
			core_video <= rnd[0];
			@(posedge clk_sys);
		end
		core_video <= 1'b0;
	endtask

	// sample held from a reset, one 256-cycle window at a random offset
	task automatic measure_audio;
		int sample;
		int offset;
		int ones;
		rnd = $random(seed);
		sample = int'(rnd[7:0]);
		offset = int'(rnd[12:8]);
		ones = 0;
		core_audio <= rnd[7:0];
		rst <= 1'b1;
		repeat (3) @(posedge clk_sys);
		rst <= 1'b0;
		repeat (offset + 1) @(posedge clk_sys);
		repeat (256) begin
			@(negedge clk_sys);
			if (audio_out)
				ones++;
		end
		@(posedge clk_sys);
		check_value("audio density", sample, ones);
	endtask

	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= 3000)
			stop_run("timeout, tests did not finish within 3000 cycles");
	end

	always @(negedge clk_sys) begin
		if (i_dut.i_asserts.fail_count != 0)
			stop_run("a concurrent assertion failed");
	end

	initial begin
		rst          = 1'b1;
		key_strobe   = 1'b0;
		key_code     = '0;
		key_pressed  = 1'b0;
		joy0         = '0;
		joy1         = '0;
		cfg_wr       = 1'b0;
		cfg_addr     = '0;
		cfg_data     = '0;
		reset_button = 1'b0;
		core_video   = 1'b0;
		core_hs      = 1'b1;
		core_vs      = 1'b1;
		core_audio   = '0;
		repeat (5) @(posedge clk_sys);
		rst <= 1'b0;
		@(posedge clk_sys);

		foreach (key_list[i]) begin
			send_key(key_list[i], 1'b1);
			send_key(key_list[i], 1'b0);
		end
		repeat (4) begin
			do begin
				rnd = $random(seed);
			end while (is_mapped(rnd[7:0]));
			send_key(rnd[7:0], 1'b1);
			send_key(rnd[7:0], 1'b0);
		end

		for (int rot = 0; rot < 2; rot++) begin
			write_cfg(2'd0, 8'(rot));
			for (int b = 0; b < 6; b++) begin
				joy0 <= 8'(1 << b);
				@(posedge clk_sys);
				joy0 <= '0;
				joy1 <= 8'(1 << b);
				@(posedge clk_sys);
				joy1 <= '0;
				@(posedge clk_sys);
			end
		end

		write_cfg(2'd2, 8'h00);
		repeat (20) @(posedge clk_sys);
		write_cfg(2'd2, 8'h00);
		repeat (5) @(posedge clk_sys);
		write_cfg(2'd2, 8'h00); // restart while holding
		repeat (20) @(posedge clk_sys);
		write_cfg(2'd3, 8'hff);
		reset_button <= 1'b1;
		repeat (3) @(posedge clk_sys);
		reset_button <= 1'b0;
		@(posedge clk_sys);

		for (int sl = 0; sl < 4; sl++) begin
			write_cfg(2'd1, 8'(sl));
			core_vs <= 1'b0;
			@(posedge clk_sys);
			core_vs <= 1'b1;
			repeat (4) run_line(12);
		end

		repeat (3) measure_audio();
		@(negedge clk_sys);

		if (i_dut.i_asserts.fail_count == 0) begin
			$display("Simulation passed");
			$finish;
		end else begin
			stop_run("assertion failures were counted");
		end
	end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+.
arcade_pkg.sv
key_decoder.sv
control_mapper.sv
core_config.sv
audio_dac.sv
video_scanline.sv
arcade_frontend.sv
arcade_frontend_asserts.sv
tb_arcade_frontend.sv

/* Makefile */
SRCS = arcade_settings.svh arcade_pkg.sv key_decoder.sv control_mapper.sv \
	core_config.sv audio_dac.sv video_scanline.sv arcade_frontend.sv \
	arcade_frontend_asserts.sv tb_arcade_frontend.sv

obj_dir/Vtb_arcade_frontend: $(SRCS) filelist.f
	verilator --binary --assert --timing --top-module tb_arcade_frontend -f filelist.f

run: obj_dir/Vtb_arcade_frontend
	./obj_dir/Vtb_arcade_frontend +verilator+error+limit+100

clean:
	rm -rf obj_dir

.PHONY: run clean
